// File: hdl/rv_ctrl_table.sv
`timescale 1ns/1ps

module rv_ctrl_table import rv_dec_pkg::*; (
   input  instr_e kind,      // from classifier
   output ctrl_t  ctrl_d,    // control bundle, before the decode register
   output logic   illegal_d  // unknown encoding
);

   always_comb begin
      ctrl_d    = ctrl_nop; // unused fields keep the nop value
      illegal_d = 1'b0;
      case (kind)
         i_lw, i_lh, i_lhu, i_lb, i_lbu: begin
            ctrl_d.regwrite = 1'b1;
            ctrl_d.memtoreg = 1'b1;    // load data to rd
            ctrl_d.alusrc   = src_imm; // base + offset
            ctrl_d.aluop    = alu_lsj;
            ctrl_d.immtype  = imm_i;
            case (kind)
               i_lh: begin
                  ctrl_d.lswidth     = ls_h;
                  ctrl_d.loadsignext = 1'b1;
               end
               i_lhu: ctrl_d.lswidth = ls_h; // zero extend
               i_lb: begin
                  ctrl_d.lswidth     = ls_b;
                  ctrl_d.loadsignext = 1'b1;
               end
               i_lbu:   ctrl_d.lswidth = ls_b;
               default: ctrl_d.lswidth = ls_w; // lw
            endcase
         end
         i_sw: begin
            ctrl_d.memwrite = 1'b1;
            ctrl_d.alusrc   = src_imm;
            ctrl_d.aluop    = alu_lsj;
            ctrl_d.immtype  = imm_s; // split immediate
         end
         i_addi, i_andi, i_ori, i_xori, i_sltiu: begin
            ctrl_d.regwrite = 1'b1;
            ctrl_d.alusrc   = src_imm;
            ctrl_d.aluop    = alu_arith; // alu decoder picks the op
            ctrl_d.immtype  = imm_i;
         end
         i_add, i_sub, i_and, i_or, i_xor, i_sltu: begin
            ctrl_d.regwrite = 1'b1;
            ctrl_d.alusrc   = src_rs2;
            ctrl_d.aluop    = alu_arith;
            ctrl_d.immtype  = imm_r; // no immediate
         end
         i_beq, i_bne: begin
            ctrl_d.branchtype = (kind == i_beq) ? br_beq : br_bne;
            ctrl_d.alusrc     = src_rs2; // compare rs1 with rs2
            ctrl_d.aluop      = alu_branch;
            ctrl_d.immtype    = imm_b;
         end
         i_jalr: begin
            ctrl_d.regwrite = 1'b1; // link address to rd
            ctrl_d.jump     = 1'b1;
            ctrl_d.alusrc   = src_imm;
            ctrl_d.aluop    = alu_lsj; // target = rs1 + imm
            ctrl_d.immtype  = imm_i;
         end
         i_csrrw, i_csrrs, i_csrrc, i_csrrwi, i_csrrsi, i_csrrci: begin
            ctrl_d.csr      = 1'b1;
            ctrl_d.regwrite = 1'b1;  // old csr value to rd
            ctrl_d.immtype  = imm_i; // csr address in imm field
            case (kind)
               i_csrrs, i_csrrsi: ctrl_d.csr_op = csr_s;
               i_csrrc, i_csrrci: ctrl_d.csr_op = csr_c;
               default:           ctrl_d.csr_op = csr_w;
            endcase
            if (kind inside {i_csrrwi, i_csrrsi, i_csrrci}) begin
               ctrl_d.csr_src = csr_uimm; // rs1 field as 5 bit uimm
            end
         end
         i_mret: begin
            ctrl_d.mret    = 1'b1; // return from trap, no rd write
            ctrl_d.immtype = imm_i;
         end
         i_lui: begin
            ctrl_d.lui      = 1'b1;
            ctrl_d.regwrite = 1'b1;
            ctrl_d.alusrc   = src_imm;
            ctrl_d.aluop    = alu_lsj;
            ctrl_d.immtype  = imm_u;
         end
         i_auipc: begin
            ctrl_d.auipc    = 1'b1; // pc + upper imm
            ctrl_d.regwrite = 1'b1;
            ctrl_d.alusrc   = src_imm;
            ctrl_d.aluop    = alu_lsj;
            ctrl_d.immtype  = imm_u;
         end
         default: begin
            ctrl_d    = ctrl_nop; // i_illegal, safe controls
            illegal_d = 1'b1;     // raise exception later in the pipe
         end
      endcase
   end

endmodule

// File: hdl/rv_dec_pkg.sv
package rv_dec_pkg;

   localparam int instr_w  = 32; // rv32 instruction word
   localparam int opcode_w = 7;  // major opcode, bits 6..0
   localparam int funct3_w = 3;  // bits 14..12
   localparam int funct7_w = 7;  // bits 31..25

   localparam logic [funct7_w-1:0] f7_base = 7'b0000000; // add and or xor sltu
   localparam logic [funct7_w-1:0] f7_alt  = 7'b0100000; // sub
   localparam logic [funct7_w-1:0] f7_mret = 7'b0011000; // mret in the system space

   typedef enum logic [opcode_w-1:0] {
      opc_load   = 7'b0000011,
      opc_store  = 7'b0100011,
      opc_op_imm = 7'b0010011, // i-type alu
      opc_op     = 7'b0110011, // r-type alu
      opc_branch = 7'b1100011,
      opc_jalr   = 7'b1100111,
      opc_system = 7'b1110011, // csr and mret
      opc_lui    = 7'b0110111,
      opc_auipc  = 7'b0010111
   } opcode_e;

   // one code per supported instruction
   typedef enum logic [4:0] {
      i_lw, i_lh, i_lhu, i_lb, i_lbu,
      i_sw,
      i_add, i_sub, i_and, i_or, i_xor, i_sltu,
      i_addi, i_andi, i_ori, i_xori, i_sltiu,
      i_beq, i_bne,
      i_jalr,
      i_csrrw, i_csrrs, i_csrrc, i_csrrwi, i_csrrsi, i_csrrci,
      i_mret,
      i_lui, i_auipc,
      i_illegal // anything not listed above
   } instr_e;

   typedef enum logic [1:0] {
      ls_w = 2'b00, // 32 bit
      ls_h = 2'b01, // 16 bit
      ls_b = 2'b10  // 8 bit
   } lswidth_e;

   typedef enum logic [2:0] {
      br_beq  = 3'b000,
      br_bne  = 3'b001,
      br_none = 3'b010 // no branch, note not zero
   } branch_e;

   typedef enum logic [1:0] {
      alu_lsj    = 2'b00, // address add: load store jalr lui auipc
      alu_branch = 2'b01, // compare
      alu_arith  = 2'b10  // op from funct3/funct7
   } aluop_e;

   typedef enum logic {
      src_rs2 = 1'b0,
      src_imm = 1'b1
   } alusrc_e;

   typedef enum logic [2:0] {
      imm_r = 3'd0, // no immediate
      imm_i = 3'd1,
      imm_s = 3'd2,
      imm_b = 3'd3,
      imm_u = 3'd4
   } immtype_e;

   typedef enum logic {
      csr_rs1  = 1'b0, // operand from rs1
      csr_uimm = 1'b1  // rs1 index used as zero-extended uimm
   } csr_src_e;

   // same code as funct3[1:0] of the csr forms
   typedef enum logic [1:0] {
      csr_w = 2'b01,
      csr_s = 2'b10,
      csr_c = 2'b11
   } csr_op_e;

   typedef struct packed {
      lswidth_e lswidth;     // [22:21]
      logic     loadsignext; // [20] 1: sign extend load
      logic     lui;         // [19]
      logic     auipc;       // [18]
      logic     mret;        // [17]
      logic     csr;         // [16] csr access enable
      csr_src_e csr_src;     // [15]
      csr_op_e  csr_op;      // [14:13]
      logic     memtoreg;    // [12] write back from memory
      logic     memwrite;    // [11]
      branch_e  branchtype;  // [10:8]
      alusrc_e  alusrc;      // [7]
      logic     regwrite;    // [6]
      logic     jump;        // [5]
      aluop_e   aluop;       // [4:3]
      immtype_e immtype;     // [2:0]
   } ctrl_t;

   // no write, no branch, no jump; reset, flush and illegal value
   localparam ctrl_t ctrl_nop = '{
      lswidth:     ls_w,
      loadsignext: 1'b0,
      lui:         1'b0,
      auipc:       1'b0,
      mret:        1'b0,
      csr:         1'b0,
      csr_src:     csr_rs1,
      csr_op:      csr_w,
      memtoreg:    1'b0,
      memwrite:    1'b0,
      branchtype:  br_none,
      alusrc:      src_imm,
      regwrite:    1'b0,
      jump:        1'b0,
      aluop:       alu_lsj,
      immtype:     imm_r
   };

endpackage

// File: hdl/rv_dec_reg.sv
`timescale 1ns/1ps

module rv_dec_reg import rv_dec_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,     // async, active low
   input  logic  flush,     // pipeline flush, load nop next edge
   input  ctrl_t ctrl_d,    // from control table
   input  logic  illegal_d,
   output ctrl_t ctrl,      // registered controls
   output logic  illinstr   // registered illegal flag
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl     <= ctrl_nop; // nothing writes out of reset
         illinstr <= 1'b0;
      end else if (flush) begin
         ctrl     <= ctrl_nop; // squash, bubble into next stage
         illinstr <= 1'b0;     // no trap from a flushed slot
      end else begin
         ctrl     <= ctrl_d;
         illinstr <= illegal_d;
      end
   end

endmodule

// File: hdl/rv_instr_classify.sv
`timescale 1ns/1ps

module rv_instr_classify import rv_dec_pkg::*; (
   input  logic [instr_w-1:0] instr, // raw instruction word
   output instr_e             kind   // which supported instruction, or i_illegal
);

   opcode_e             opcode; // major opcode
   logic [funct3_w-1:0] funct3;
   logic [funct7_w-1:0] funct7;

   assign opcode = opcode_e'(instr[opcode_w-1:0]);
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   always_comb begin
      kind = i_illegal; // default for unknown encodings
      case (opcode)
         opc_load: begin
            case (funct3)
               3'b000:  kind = i_lb;
               3'b001:  kind = i_lh;
               3'b010:  kind = i_lw;
               3'b100:  kind = i_lbu;
               3'b101:  kind = i_lhu;
               default: kind = i_illegal;
            endcase
         end
         opc_store: begin
            if (funct3 == 3'b010) kind = i_sw; // sb, sh not supported
         end
         opc_op_imm: begin
            case (funct3)
               3'b000:  kind = i_addi;
               3'b011:  kind = i_sltiu;
               3'b100:  kind = i_xori;
               3'b110:  kind = i_ori;
               3'b111:  kind = i_andi;
               default: kind = i_illegal; // shifts, slti
            endcase
         end
         opc_op: begin
            // r-type needs an exact funct7
            if (funct7 == f7_base) begin
               case (funct3)
                  3'b000:  kind = i_add;
                  3'b011:  kind = i_sltu;
                  3'b100:  kind = i_xor;
                  3'b110:  kind = i_or;
                  3'b111:  kind = i_and;
                  default: kind = i_illegal;
               endcase
            end else if (funct7 == f7_alt && funct3 == 3'b000) begin
               kind = i_sub;
            end
         end
         opc_branch: begin
            case (funct3)
               3'b000:  kind = i_beq;
               3'b001:  kind = i_bne;
               default: kind = i_illegal; // blt bge ... not decoded
            endcase
         end
         opc_jalr: begin
            if (funct3 == 3'b000) kind = i_jalr;
         end
         opc_system: begin
            case (funct3)
               3'b000: begin
                  if (funct7 == f7_mret) kind = i_mret; // ecall/ebreak stay illegal
               end
               3'b001:  kind = i_csrrw;
               3'b010:  kind = i_csrrs;
               3'b011:  kind = i_csrrc;
               3'b101:  kind = i_csrrwi;
               3'b110:  kind = i_csrrsi;
               3'b111:  kind = i_csrrci;
               default: kind = i_illegal;
            endcase
         end
         opc_lui:   kind = i_lui;   // no funct fields
         opc_auipc: kind = i_auipc;
         default:   kind = i_illegal; // jal, fence, zero word ...
      endcase
   end

endmodule

// File: hdl/rv_maindec.sv
`timescale 1ns/1ps

module rv_maindec import rv_dec_pkg::*; (
   input  logic               clk,
   input  logic               rst_n,
   input  logic [instr_w-1:0] instr,    // new word every cycle
   input  logic               flush,    // level, nop on next edge
   output ctrl_t              ctrl,     // one cycle after instr
   output logic               illinstr
);

   instr_e kind;      // classified instruction
   ctrl_t  ctrl_d;    // table output, unregistered
   logic   illegal_d;

   rv_instr_classify rv_instr_classify_inst (
      .instr (instr),
      .kind  (kind)
   );

   rv_ctrl_table rv_ctrl_table_inst (
      .kind      (kind),
      .ctrl_d    (ctrl_d),
      .illegal_d (illegal_d)
   );

   rv_dec_reg rv_dec_reg_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .ctrl_d    (ctrl_d),
      .illegal_d (illegal_d),
      .ctrl      (ctrl),
      .illinstr  (illinstr)
   );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f rv_maindec.f --top-module rv_maindec_tb -o rv_maindec_sim

./obj_dir/rv_maindec_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
   exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
   echo "no pass line found in sim.log"
   exit 1
fi
exit 0

// File: rv_maindec.f
+incdir+verif
hdl/rv_dec_pkg.sv
hdl/rv_instr_classify.sv
hdl/rv_ctrl_table.sv
hdl/rv_dec_reg.sv
hdl/rv_maindec.sv
verif/rv_maindec_tb.sv

// File: verif/rv_maindec_vectors.svh
`ifndef RV_MAINDEC_VECTORS_SVH
`define RV_MAINDEC_VECTORS_SVH

// one row: base word, bits to randomise, flush level, expected outputs
typedef struct packed {
   logic [31:0] word;    // fixed opcode and funct fields
   logic [31:0] rmask;   // 1 = bit filled from the lfsr
   logic        flush;
   ctrl_t       exp_ctrl;
   logic        exp_ill;
} vec_t;

localparam int n_vec  = 39;
localparam int n_rand = 32; // extra rows picked at random from the table

localparam logic [31:0] m_r = 32'h01ff8f80; // rd rs1 rs2
localparam logic [31:0] m_i = 32'hffff8f80; // also s and b layouts
localparam logic [31:0] m_u = 32'hffffff80; // rd and upper imm

vec_t vec_tab [n_vec];

function automatic logic [31:0] enc(input logic [6:0] f7, input logic [2:0] f3,
                                   input logic [6:0] opc);
   enc = {f7, 10'b0, f3, 5'b0, opc}; // other fields zero
endfunction

function automatic ctrl_t exp_load(input lswidth_e w, input logic sext);
   ctrl_t c;
   c             = ctrl_nop;
   c.regwrite    = 1'b1;
   c.memtoreg    = 1'b1;
   c.alusrc      = src_imm;
   c.immtype     = imm_i;
   c.lswidth     = w;
   c.loadsignext = sext;
   return c;
endfunction

function automatic ctrl_t exp_alu(input logic use_imm);
   ctrl_t c;
   c          = ctrl_nop;
   c.regwrite = 1'b1;
   c.aluop    = alu_arith;
   c.alusrc   = use_imm ? src_imm : src_rs2;
   c.immtype  = use_imm ? imm_i : imm_r;
   return c;
endfunction

function automatic ctrl_t exp_misc(input instr_e k, input logic [2:0] f3);
   ctrl_t c;
   c = ctrl_nop;
   case (k)
      i_sw: begin
         c.memwrite = 1'b1;
         c.immtype  = imm_s;
      end
      i_beq, i_bne: begin
         c.branchtype = (k == i_beq) ? br_beq : br_bne;
         c.alusrc     = src_rs2;
         c.aluop      = alu_branch;
         c.immtype    = imm_b;
      end
      i_jalr: begin
         c.regwrite = 1'b1;
         c.jump     = 1'b1;
         c.immtype  = imm_i;
      end
      i_csrrw: begin // all six forms, op and source from funct3
         c.csr      = 1'b1;
         c.regwrite = 1'b1;
         c.immtype  = imm_i;
         c.csr_op   = csr_op_e'(f3[1:0]);
         c.csr_src  = f3[2] ? csr_uimm : csr_rs1;
      end
      i_mret: begin
         c.mret    = 1'b1;
         c.immtype = imm_i;
      end
      default: begin // lui, auipc
         c.lui      = (k == i_lui);
         c.auipc    = (k == i_auipc);
         c.regwrite = 1'b1;
         c.immtype  = imm_u;
      end
   endcase
   return c;
endfunction

task automatic set_row(input int i, input logic [31:0] w, input logic [31:0] m,
                       input logic fl, input ctrl_t c, input logic ill);
   vec_tab[i] = '{word: w, rmask: m, flush: fl, exp_ctrl: c, exp_ill: ill};
endtask

task automatic load_vectors();
   set_row(0,  enc(7'h00, 3'd2, 7'h03), m_i, 1'b0, exp_load(ls_w, 1'b0), 1'b0); // lw
   set_row(1,  enc(7'h00, 3'd1, 7'h03), m_i, 1'b0, exp_load(ls_h, 1'b1), 1'b0); // lh
   set_row(2,  enc(7'h00, 3'd5, 7'h03), m_i, 1'b0, exp_load(ls_h, 1'b0), 1'b0); // lhu
   set_row(3,  enc(7'h00, 3'd0, 7'h03), m_i, 1'b0, exp_load(ls_b, 1'b1), 1'b0); // lb
   set_row(4,  enc(7'h00, 3'd4, 7'h03), m_i, 1'b0, exp_load(ls_b, 1'b0), 1'b0); // lbu
   set_row(5,  enc(7'h00, 3'd2, 7'h23), m_i, 1'b0, exp_misc(i_sw, 3'd0), 1'b0);
   set_row(6,  enc(7'h00, 3'd0, 7'h13), m_i, 1'b0, exp_alu(1'b1), 1'b0); // addi
   set_row(7,  enc(7'h00, 3'd7, 7'h13), m_i, 1'b0, exp_alu(1'b1), 1'b0); // andi
   set_row(8,  enc(7'h00, 3'd6, 7'h13), m_i, 1'b0, exp_alu(1'b1), 1'b0); // ori
   set_row(9,  enc(7'h00, 3'd4, 7'h13), m_i, 1'b0, exp_alu(1'b1), 1'b0); // xori
   set_row(10, enc(7'h00, 3'd3, 7'h13), m_i, 1'b0, exp_alu(1'b1), 1'b0); // sltiu
   set_row(11, enc(7'h00, 3'd0, 7'h33), m_r, 1'b0, exp_alu(1'b0), 1'b0); // add
   set_row(12, enc(7'h20, 3'd0, 7'h33), m_r, 1'b0, exp_alu(1'b0), 1'b0); // sub
   set_row(13, enc(7'h00, 3'd7, 7'h33), m_r, 1'b0, exp_alu(1'b0), 1'b0); // and
   set_row(14, enc(7'h00, 3'd6, 7'h33), m_r, 1'b0, exp_alu(1'b0), 1'b0); // or
   set_row(15, enc(7'h00, 3'd4, 7'h33), m_r, 1'b0, exp_alu(1'b0), 1'b0); // xor
   set_row(16, enc(7'h00, 3'd3, 7'h33), m_r, 1'b0, exp_alu(1'b0), 1'b0); // sltu
   set_row(17, enc(7'h00, 3'd0, 7'h63), m_i, 1'b0, exp_misc(i_beq, 3'd0), 1'b0);
   set_row(18, enc(7'h00, 3'd1, 7'h63), m_i, 1'b0, exp_misc(i_bne, 3'd0), 1'b0);
   set_row(19, enc(7'h00, 3'd0, 7'h67), m_i, 1'b0, exp_misc(i_jalr, 3'd0), 1'b0);
   set_row(20, enc(7'h00, 3'd1, 7'h73), m_i, 1'b0, exp_misc(i_csrrw, 3'd1), 1'b0); // csrrw
   set_row(21, enc(7'h00, 3'd2, 7'h73), m_i, 1'b0, exp_misc(i_csrrw, 3'd2), 1'b0); // csrrs
   set_row(22, enc(7'h00, 3'd3, 7'h73), m_i, 1'b0, exp_misc(i_csrrw, 3'd3), 1'b0);
   set_row(23, enc(7'h00, 3'd5, 7'h73), m_i, 1'b0, exp_misc(i_csrrw, 3'd5), 1'b0); // csrrwi
   set_row(24, enc(7'h00, 3'd6, 7'h73), m_i, 1'b0, exp_misc(i_csrrw, 3'd6), 1'b0);
   set_row(25, enc(7'h00, 3'd7, 7'h73), m_i, 1'b0, exp_misc(i_csrrw, 3'd7), 1'b0); // csrrci
   set_row(26, 32'h30200073, '0, 1'b0, exp_misc(i_mret, 3'd0), 1'b0);
   set_row(27, enc(7'h00, 3'd0, 7'h37), m_u, 1'b0, exp_misc(i_lui, 3'd0), 1'b0);
   set_row(28, enc(7'h00, 3'd0, 7'h17), m_u, 1'b0, exp_misc(i_auipc, 3'd0), 1'b0);
   set_row(29, enc(7'h00, 3'd0, 7'h6f), m_u, 1'b0, ctrl_nop, 1'b1); // jal
   set_row(30, enc(7'h00, 3'd1, 7'h13), m_r, 1'b0, ctrl_nop, 1'b1); // slli
   set_row(31, enc(7'h20, 3'd7, 7'h33), m_r, 1'b0, ctrl_nop, 1'b1); // and, bad funct7
   set_row(32, 32'h0000000f, '0, 1'b0, ctrl_nop, 1'b1); // fence
   set_row(33, 32'h00000000, '0, 1'b0, ctrl_nop, 1'b1); // zero word
   set_row(34, 32'h10200073, '0, 1'b0, ctrl_nop, 1'b1); // mret, wrong funct7
   set_row(35, enc(7'h00, 3'd2, 7'h23), m_i, 1'b1, ctrl_nop, 1'b0); // flushed sw
   set_row(36, enc(7'h00, 3'd0, 7'h33), m_r, 1'b0, exp_alu(1'b0), 1'b0);
   set_row(37, enc(7'h00, 3'd1, 7'h73), m_i, 1'b1, ctrl_nop, 1'b0); // flushed csrrw
   set_row(38, enc(7'h00, 3'd0, 7'h37), m_u, 1'b0, exp_misc(i_lui, 3'd0), 1'b0);
endtask

`endif

// File: verif/rv_maindec_tb.sv
`timescale 1ns/1ps

module rv_maindec_tb import rv_dec_pkg::*; ();

   `include "rv_maindec_vectors.svh"

   localparam int cycle_limit = 2 * n_vec + n_rand + 20;

   logic        clk;
   logic        rst_n;
   logic [31:0] instr;
   logic        flush;
   ctrl_t       ctrl;
   logic        illinstr;

   logic [31:0] lfsr_state; // fibonacci lfsr, taps 32 22 2 1
   int          cycles;
   vec_t        prev;       // row whose result is due at the next check

   rv_maindec rv_maindec_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .instr    (instr),
      .flush    (flush),
      .ctrl     (ctrl),
      .illinstr (illinstr)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk; // 40 ns period

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout, the run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAIL");
         $fatal(1, "simulation stopped on timeout");
      end
   end

   // one lfsr step, returns the new bit
   function automatic logic lfsr_bit();
      logic nb;
      nb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], nb};
      return nb;
   endfunction

   // fill masked bits of a row word from the lfsr
   function automatic logic [31:0] randomise(input logic [31:0] w, input logic [31:0] m);
      logic [31:0] r;
      r = w;
      for (int b = 0; b < 32; b++) begin
         if (m[b]) r[b] = lfsr_bit();
      end
      return r;
   endfunction

   task automatic check_ctrl(input ctrl_t got, input ctrl_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: ctrl got %h expected %h", $time, got, exp);
         $display("TEST FAIL");
         $fatal(1, "ctrl check failed");
      end
   endtask

   task automatic check_illegal(input logic got, input logic exp);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: illinstr got %b expected %b", $time, got, exp);
         $display("TEST FAIL");
         $fatal(1, "illinstr check failed");
      end
   endtask

   // drive one row, then check the row before it at the falling edge
   task automatic apply_row(input vec_t v);
      @(posedge clk);
      instr <= randomise(v.word, v.rmask);
      flush <= v.flush;
      @(negedge clk);
      check_ctrl(ctrl, prev.exp_ctrl);
      check_illegal(illinstr, prev.exp_ill);
      prev = v;
   endtask

   initial begin
      int idx;
      lfsr_state = 32'hea0619a5;
      cycles     = 0;
      rst_n      = 1'b0;
      instr      = '0;
      flush      = 1'b1; // first edge after reset loads a bubble
      load_vectors();
      prev = '{word: '0, rmask: '0, flush: 1'b1, exp_ctrl: ctrl_nop, exp_ill: 1'b0};
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_ctrl(ctrl, ctrl_nop); // during reset
      check_illegal(illinstr, 1'b0);
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_ctrl(ctrl, ctrl_nop); // released, before any load
      check_illegal(illinstr, 1'b0);
      for (int i = 0; i < n_vec; i++) begin
         apply_row(vec_tab[i]);
      end
      // back to back rows in random order
      for (int i = 0; i < n_rand; i++) begin
         idx = 0;
         for (int b = 0; b < 6; b++) idx = {idx[30:0], lfsr_bit()};
         apply_row(vec_tab[idx % n_vec]);
      end
      apply_row('{word: '0, rmask: '0, flush: 1'b1, exp_ctrl: ctrl_nop, exp_ill: 1'b0});
      $display("TEST PASS");
      $finish;
   end

endmodule
